// ==== verilog.f ====
conv_pkg.sv
conv_ctrl.sv
kernel_bank.sv
tile_buffer.sv
window_mac.sv
max_pool.sv
conv_top.sv
tb_conv.sv

// ==== Makefile ====
TOP = tb_conv

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -Wall -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^Regression passed$$"

clean:
	rm -rf obj_dir

// ==== tb_conv.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_conv;
    import conv_pkg::*;

    localparam int CLK_PERIOD     = 100;
    localparam int CLK_HALF       = CLK_PERIOD / 2;
    localparam int DRIVE_DLY      = 10;
    localparam int RESET_CYCLES   = 2;
    localparam int COMPUTE_CYCLES = 4;
    localparam int LATENCY        = 6;
    localparam int SEED           = 32'h7b70;
    localparam int NUM_TILES      = TILES_PER_ROW * TILES_PER_ROW;
    localparam int FULL_TILE      = NUM_CH * TILE_SIZE * TILE_SIZE;
    localparam int PART_TILE      = NUM_CH * TILE_SIZE * TILE_STEP;
    localparam int FRAME_BEATS    = NUM_CH * K_SIZE * K_SIZE
                                    + TILES_PER_ROW
                                    * (FULL_TILE + (TILES_PER_ROW - 1) * PART_TILE);
    localparam int NUM_FRAMES     = 8;
    localparam int WATCHDOG_CYCLES = NUM_FRAMES * FRAME_BEATS * 2 + 500;

    localparam int K_ONES   = 0;
    localparam int K_NEG    = 1;
    localparam int K_CENTRE = 2;
    localparam int K_RAND   = 3;
    localparam int I_CONST  = 0;
    localparam int I_RAMP   = 1;
    localparam int I_RAND   = 2;

    // abort_at > 0 resets the DUT right after the last beat of that tile
    typedef struct packed {
        int kmode;
        int imode;
        int value;
        int abort_at;
        int fixed;
        int exp_val;
    } frame_t;

    localparam frame_t FRAMES [NUM_FRAMES] = '{
        '{K_ONES,   I_CONST, 3,  0, 1, 108},
        '{K_ONES,   I_CONST, -2, 0, 1, 0},
        '{K_NEG,    I_CONST, -2, 0, 1, 72},
        '{K_CENTRE, I_RAMP,  0,  0, 0, 0},
        '{K_RAND,   I_RAND,  0,  0, 0, 0},
        '{K_RAND,   I_RAND,  0,  0, 0, 0},
        '{K_RAND,   I_RAND,  0,  4, 0, 0},
        '{K_RAND,   I_RAND,  0,  0, 0, 0}
    };

    logic    i_clk;
    logic    i_rst;
    logic    i_valid;
    sample_t i_data;
    logic    o_valid;
    acc_t    o_data;

    integer  seed;
    int      kern [NUM_CH][K_SIZE][K_SIZE];
    int      img [NUM_CH][IMG_SIZE][IMG_SIZE];
    acc_t    exp_q [$];
    acc_t    got_q [$];
    time     tile_end_q [$];
    time     last_accept;
    int      pixel_errs;
    int      count_errs;
    int      timing_errs;
    int      other_errs;

    conv_top DUT (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_valid (i_valid),
        .i_data  (i_data),
        .o_valid (o_valid),
        .o_data  (o_data)
    );

    initial
    begin
        i_clk = 1'b0;
        forever #CLK_HALF i_clk = ~i_clk;
    end

    task automatic check_pixel(input acc_t got, input acc_t exp, input string what);
        if (got !== exp)
        begin
            pixel_errs++;
            $display("Fail %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp)
        begin
            count_errs++;
            $display("Fail %0t ns: %s gave %0d outputs, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_latency(input int got, input int exp);
        if (got != exp)
        begin
            timing_errs++;
            $display("Fail %0t ns: o_valid %0d cycles after last beat, expected %0d",
                     $time, got, exp);
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge i_clk)
    begin
        time t0;
        if (o_valid)
        begin
            got_q.push_back(o_data);
            if (tile_end_q.size() == 0)
            begin
                other_errs++;
                $display("o_valid pulsed at %0t ns while no tile was waiting for a result",
                         $time);
            end
            else
            begin
                t0 = tile_end_q.pop_front();
                check_latency(int'(($time - CLK_HALF - t0) / CLK_PERIOD), LATENCY);
            end
        end
    end

    task automatic build_frame(input frame_t f);
        sample_t s;
        for (int c = 0; c < NUM_CH; c++)
            for (int r = 0; r < K_SIZE; r++)
                for (int j = 0; j < K_SIZE; j++)
                begin
                    s = $random(seed);
                    case (f.kmode)
                        K_ONES:   kern[c][r][j] = 1;
                        K_NEG:    kern[c][r][j] = -1;
                        K_CENTRE: kern[c][r][j] = (r == 1 && j == 1) ? 1 : 0;
                        default:  kern[c][r][j] = int'(s);
                    endcase
                end
        for (int c = 0; c < NUM_CH; c++)
            for (int y = 0; y < IMG_SIZE; y++)
                for (int x = 0; x < IMG_SIZE; x++)
                begin
                    s = $random(seed);
                    case (f.imode)
                        I_CONST: img[c][y][x] = f.value;
                        // ramp stays inside the 5-bit range
                        I_RAMP:  img[c][y][x] = (x + 2 * y + c) % 16 - 4;
                        default: img[c][y][x] = int'(s);
                    endcase
                end
    endtask

    // 3x3 conv summed over channels, then 2x2 max against zero
    task automatic model_frame();
        int best;
        int sum;
        exp_q.delete();
        for (int tr = 0; tr < TILES_PER_ROW; tr++)
            for (int tc = 0; tc < TILES_PER_ROW; tc++)
            begin
                best = 0;
                for (int dy = 0; dy < 2; dy++)
                    for (int dx = 0; dx < 2; dx++)
                    begin
                        sum = 0;
                        for (int c = 0; c < NUM_CH; c++)
                            for (int r = 0; r < K_SIZE; r++)
                                for (int j = 0; j < K_SIZE; j++)
                                    sum += kern[c][r][j]
                                           * img[c][TILE_STEP * tr + dy + r]
                                                [TILE_STEP * tc + dx + j];
                        if (sum > best)
                            best = sum;
                    end
                exp_q.push_back(acc_t'(best));
            end
    endtask

    task automatic send_beat(input int value);
        i_valid = 1'b1;
        i_data  = sample_t'(value);
        @(posedge i_clk);
        last_accept = $time;
        #DRIVE_DLY;
    endtask

    task automatic send_tile(input int tr, input int tc, input int limit);
        int first;
        int n;
        first = (tc == 0) ? 0 : TILE_STEP;
        n     = 0;
        for (int c = 0; c < NUM_CH; c++)
            for (int r = 0; r < TILE_SIZE; r++)
                for (int j = first; j < TILE_SIZE; j++)
                    if (n < limit)
                    begin
                        send_beat(img[c][TILE_STEP * tr + r][TILE_STEP * tc + j]);
                        n++;
                    end
    endtask

    task automatic end_tile();
        i_valid = 1'b0;
        tile_end_q.push_back(last_accept);
        repeat (COMPUTE_CYCLES) @(posedge i_clk);
        #DRIVE_DLY;
    endtask

    task automatic reset_mid_frame();
        i_valid = 1'b0;
        i_rst   = 1'b0;
        repeat (RESET_CYCLES) @(posedge i_clk);
        #DRIVE_DLY;
        i_rst = 1'b1;
        // monitor flags any pulse here
        repeat (3 * LATENCY) @(posedge i_clk);
        #DRIVE_DLY;
    endtask

    task automatic run_frame(input frame_t f, input int idx);
        int   n_exp;
        int   waited;
        acc_t exp;
        build_frame(f);
        model_frame();
        got_q.delete();
        n_exp = NUM_TILES;
        for (int c = 0; c < NUM_CH; c++)
            for (int r = 0; r < K_SIZE; r++)
                for (int j = 0; j < K_SIZE; j++)
                    send_beat(kern[c][r][j]);
        for (int t = 0; t < NUM_TILES; t++)
        begin
            if (f.abort_at != 0 && t == f.abort_at)
            begin
                // the reset lands while this tile is being computed
                send_tile(t / TILES_PER_ROW, t % TILES_PER_ROW, FULL_TILE);
                n_exp = t;
                break;
            end
            send_tile(t / TILES_PER_ROW, t % TILES_PER_ROW, FULL_TILE);
            end_tile();
        end
        if (n_exp != NUM_TILES)
            reset_mid_frame();
        else
        begin
            waited = 0;
            while (got_q.size() < n_exp && waited < 2 * LATENCY)
            begin
                @(posedge i_clk);
                #DRIVE_DLY;
                waited++;
            end
        end
        check_count(got_q.size(), n_exp, $sformatf("frame %0d", idx));
        for (int i = 0; i < got_q.size() && i < n_exp; i++)
        begin
            exp = (f.fixed != 0) ? acc_t'(f.exp_val) : exp_q[i];
            check_pixel(got_q[i], exp, $sformatf("frame %0d pixel %0d", idx, i));
        end
    endtask

    initial
    begin
        i_rst       = 1'b0;
        i_valid     = 1'b0;
        i_data      = '0;
        seed        = SEED;
        last_accept = 0;
        pixel_errs  = 0;
        count_errs  = 0;
        timing_errs = 0;
        other_errs  = 0;
        repeat (RESET_CYCLES) @(posedge i_clk);
        #DRIVE_DLY;
        i_rst = 1'b1;
        for (int idx = 0; idx < NUM_FRAMES; idx++)
            run_frame(FRAMES[idx], idx);
        $display("errors: pixel %0d, count %0d, timing %0d, other %0d",
                 pixel_errs, count_errs, timing_errs, other_errs);
        if (pixel_errs + count_errs + timing_errs + other_errs == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the frames did not finish",
                 WATCHDOG_CYCLES);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== conv_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module conv_top (
    input  wire                    i_clk,
    input  wire                    i_rst,
    input  wire                    i_valid,
    input  wire conv_pkg::sample_t i_data,
    output wire                    o_valid,
    output wire conv_pkg::acc_t    o_data
);
    import conv_pkg::*;

    wire buf_wr_t     wr;
    wire sample_t     wr_data;
    wire mac_req_t    mac_req;
    wire kernel_set_t kernels;
    wire tile_set_t   tile;
    wire mac_res_t    mac_res;

    conv_ctrl u_ctrl (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_valid   (i_valid),
        .i_data    (i_data),
        .o_wr      (wr),
        .o_wr_data (wr_data),
        .o_mac     (mac_req)
    );

    kernel_bank u_kernels (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_wr      (wr),
        .i_wr_data (wr_data),
        .o_kernels (kernels)
    );

    tile_buffer u_tile (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_wr      (wr),
        .i_wr_data (wr_data),
        .o_tile    (tile)
    );

    window_mac u_mac (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_kernels (kernels),
        .i_tile    (tile),
        .i_req     (mac_req),
        .o_res     (mac_res)
    );

    max_pool u_pool (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_res     (mac_res),
        .o_valid   (o_valid),
        .o_data    (o_data)
    );

endmodule

`default_nettype wire

// ==== max_pool.sv ====
`timescale 1ns/100ps
`default_nettype none

module max_pool (
    input  wire                   i_clk,
    input  wire                   i_rst,
    input  wire conv_pkg::mac_res_t i_res,
    output logic                  o_valid,
    output conv_pkg::acc_t        o_data
);
    import conv_pkg::*;

    acc_t max_q;
    acc_t cand;

    // max_q sits at zero at group start, which gives the relu
    assign cand = (i_res.sum > max_q) ? i_res.sum : max_q;

    always_ff @(posedge i_clk or negedge i_rst)
    begin
        if (!i_rst)
        begin
            max_q   <= '0;
            o_valid <= 1'b0;
            o_data  <= '0;
        end
        else
        begin
            o_valid <= i_res.valid && i_res.last;
            if (i_res.valid)
            begin
                if (i_res.last)
                begin
                    o_data <= cand;
                    max_q  <= '0;
                end
                else
                    max_q <= cand;
            end
        end
    end

endmodule

`default_nettype wire

// ==== window_mac.sv ====
`timescale 1ns/100ps
`default_nettype none

module window_mac (
    input  wire                      i_clk,
    input  wire                      i_rst,
    input  wire conv_pkg::kernel_set_t i_kernels,
    input  wire conv_pkg::tile_set_t   i_tile,
    input  wire conv_pkg::mac_req_t    i_req,
    output conv_pkg::mac_res_t       o_res
);
    import conv_pkg::*;

    acc_t sum_c;

    // dx moves along columns, dy along rows
    always_comb
    begin
        sample_t k_s;
        sample_t t_s;
        acc_t    prod;
        sum_c = '0;
        for (int c = 0; c < NUM_CH; c++)
        begin
            for (int r = 0; r < K_SIZE; r++)
            begin
                for (int j = 0; j < K_SIZE; j++)
                begin
                    k_s   = i_kernels[(c * K_SIZE + r) * K_SIZE + j];
                    t_s   = i_tile[(c * TILE_SIZE + r + int'(i_req.dy)) * TILE_SIZE
                                   + j + int'(i_req.dx)];
                    prod  = k_s * t_s;
                    sum_c = sum_c + prod;
                end
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst)
    begin
        if (!i_rst)
            o_res <= '0;
        else
        begin
            o_res.valid <= i_req.go;
            // offset (1,1) closes the group of four
            o_res.last  <= i_req.go && i_req.dx && i_req.dy;
            o_res.sum   <= sum_c;
        end
    end

endmodule

`default_nettype wire

// ==== tile_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

module tile_buffer (
    input  wire                   i_clk,
    input  wire                   i_rst,
    input  wire conv_pkg::buf_wr_t i_wr,
    input  wire conv_pkg::sample_t i_wr_data,
    output conv_pkg::tile_set_t   o_tile
);
    import conv_pkg::*;

    tile_set_t         tile_q;
    logic [TIDX_W-1:0] tidx;

    assign tidx = TIDX_W'((int'(i_wr.ch) * TILE_SIZE + int'(i_wr.row)) * TILE_SIZE
                          + int'(i_wr.col));

    always_ff @(posedge i_clk or negedge i_rst)
    begin
        if (!i_rst)
            tile_q <= '0;
        else
        begin
            // slide the window left by one tile step in every channel
            if (i_wr.shift)
            begin
                for (int c = 0; c < NUM_CH; c++)
                begin
                    for (int r = 0; r < TILE_SIZE; r++)
                    begin
                        for (int j = 0; j < TILE_SIZE - TILE_STEP; j++)
                        begin
                            tile_q[(c * TILE_SIZE + r) * TILE_SIZE + j] <=
                                tile_q[(c * TILE_SIZE + r) * TILE_SIZE + j + TILE_STEP];
                        end
                    end
                end
            end
            // the new sample overrides the shifted value at its slot
            if (i_wr.tile_we)
                tile_q[tidx] <= i_wr_data;
        end
    end

    assign o_tile = tile_q;

    // the shift only comes with the first beat of a partial tile
    a_shift_first_beat: assert property (@(posedge i_clk) disable iff (!i_rst)
        i_wr.shift |-> i_wr.tile_we && (i_wr.col == POS_W'(TILE_STEP)));

endmodule

`default_nettype wire

// ==== kernel_bank.sv ====
`timescale 1ns/100ps
`default_nettype none

module kernel_bank (
    input  wire                   i_clk,
    input  wire                   i_rst,
    input  wire conv_pkg::buf_wr_t i_wr,
    input  wire conv_pkg::sample_t i_wr_data,
    output conv_pkg::kernel_set_t o_kernels
);
    import conv_pkg::*;

    kernel_set_t       kern_q;
    logic [KIDX_W-1:0] kidx;

    assign kidx = KIDX_W'((int'(i_wr.ch) * K_SIZE + int'(i_wr.row)) * K_SIZE
                          + int'(i_wr.col));

    always_ff @(posedge i_clk or negedge i_rst)
    begin
        if (!i_rst)
            kern_q <= '0;
        else if (i_wr.kern_we)
            kern_q[kidx] <= i_wr_data;
    end

    assign o_kernels = kern_q;

    // kernel beats use the 3x3 part of the shared counters
    a_kern_addr: assert property (@(posedge i_clk) disable iff (!i_rst)
        i_wr.kern_we |-> (i_wr.row < POS_W'(K_SIZE)) && (i_wr.col < POS_W'(K_SIZE))
                         && (i_wr.ch < CH_W'(NUM_CH)));

endmodule

`default_nettype wire

// ==== conv_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module conv_ctrl (
    input  wire                i_clk,
    input  wire                i_rst,
    input  wire                i_valid,
    input  wire conv_pkg::sample_t i_data,
    output conv_pkg::buf_wr_t  o_wr,
    output conv_pkg::sample_t  o_wr_data,
    output conv_pkg::mac_req_t o_mac
);
    import conv_pkg::*;

    typedef enum logic [1:0] {
        ST_KERN,
        ST_TILE,
        ST_COMP
    } state_t;

    state_t           state;
    logic [CH_W-1:0]  ch;
    logic [POS_W-1:0] row;
    logic [POS_W-1:0] col;
    logic [POS_W-1:0] tile_col;
    logic [POS_W-1:0] tile_row;
    logic [1:0]       phase;
    logic             partial;
    logic [POS_W-1:0] col_first;
    logic             tile_beat;

    // later tiles in a row only carry the two new columns
    assign partial   = (tile_col != '0);
    assign col_first = partial ? POS_W'(TILE_STEP) : '0;
    assign tile_beat = i_valid && (state == ST_TILE);

    always_comb
    begin
        o_wr         = '0;
        o_wr.kern_we = i_valid && (state == ST_KERN);
        o_wr.tile_we = tile_beat;
        o_wr.shift   = tile_beat && partial && (ch == '0) && (row == '0)
                       && (col == POS_W'(TILE_STEP));
        o_wr.ch      = ch;
        o_wr.row     = row;
        o_wr.col     = col;
    end

    assign o_wr_data = i_data;

    always_ff @(posedge i_clk or negedge i_rst)
    begin
        if (!i_rst)
        begin
            state    <= ST_KERN;
            ch       <= '0;
            row      <= '0;
            col      <= '0;
            tile_col <= '0;
            tile_row <= '0;
            phase    <= '0;
        end
        else
        begin
            case (state)
                ST_KERN:
                begin
                    if (i_valid)
                    begin
                        if (col == POS_W'(K_SIZE - 1))
                        begin
                            col <= '0;
                            if (row == POS_W'(K_SIZE - 1))
                            begin
                                row <= '0;
                                if (ch == CH_W'(NUM_CH - 1))
                                begin
                                    ch    <= '0;
                                    state <= ST_TILE;
                                end
                                else
                                    ch <= ch + 1'b1;
                            end
                            else
                                row <= row + 1'b1;
                        end
                        else
                            col <= col + 1'b1;
                    end
                end
                ST_TILE:
                begin
                    if (i_valid)
                    begin
                        if (col == POS_W'(TILE_SIZE - 1))
                        begin
                            col <= col_first;
                            if (row == POS_W'(TILE_SIZE - 1))
                            begin
                                row <= '0;
                                if (ch == CH_W'(NUM_CH - 1))
                                begin
                                    ch    <= '0;
                                    state <= ST_COMP;
                                end
                                else
                                    ch <= ch + 1'b1;
                            end
                            else
                                row <= row + 1'b1;
                        end
                        else
                            col <= col + 1'b1;
                    end
                end
                ST_COMP:
                begin
                    phase <= phase + 1'b1;
                    if (phase == 2'd3)
                    begin
                        if (tile_col == POS_W'(TILES_PER_ROW - 1))
                        begin
                            tile_col <= '0;
                            col      <= '0;
                            if (tile_row == POS_W'(TILES_PER_ROW - 1))
                            begin
                                // frame done, next frame starts with kernels
                                tile_row <= '0;
                                state    <= ST_KERN;
                            end
                            else
                            begin
                                tile_row <= tile_row + 1'b1;
                                state    <= ST_TILE;
                            end
                        end
                        else
                        begin
                            tile_col <= tile_col + 1'b1;
                            col      <= POS_W'(TILE_STEP);
                            state    <= ST_TILE;
                        end
                    end
                end
                default:
                    state <= ST_KERN;
            endcase
        end
    end

    // requests trail the compute phase by one cycle
    always_ff @(posedge i_clk or negedge i_rst)
    begin
        if (!i_rst)
            o_mac <= '0;
        else
        begin
            o_mac.go <= (state == ST_COMP);
            o_mac.dx <= phase[0];
            o_mac.dy <= phase[1];
        end
    end

    // source has no back-pressure, so it must stay quiet during compute
    a_no_beat_in_compute: assert property (@(posedge i_clk) disable iff (!i_rst)
        !((state == ST_COMP) && i_valid));

    a_counters_in_range: assert property (@(posedge i_clk) disable iff (!i_rst)
        (ch < CH_W'(NUM_CH)) && (row < POS_W'(TILE_SIZE)) && (col < POS_W'(TILE_SIZE))
        && (tile_col < POS_W'(TILES_PER_ROW)) && (tile_row < POS_W'(TILES_PER_ROW)));

endmodule

`default_nettype wire

// ==== conv_pkg.sv ====
`default_nettype none

package conv_pkg;

    localparam int DATA_W        = 5;
    localparam int NUM_CH        = 4;
    localparam int K_SIZE        = 3;
    localparam int TILE_SIZE     = 4;
    localparam int IMG_SIZE      = 8;
    localparam int TILE_STEP     = 2;
    localparam int TILES_PER_ROW = (IMG_SIZE - TILE_SIZE) / TILE_STEP + 1;
    // 36 signed 10-bit products fit comfortably
    localparam int ACC_W         = 16;

    localparam int CH_W          = $clog2(NUM_CH + 1);
    localparam int POS_W         = $clog2(IMG_SIZE);

    localparam int KERN_WORDS    = NUM_CH * K_SIZE * K_SIZE;
    localparam int TILE_WORDS    = NUM_CH * TILE_SIZE * TILE_SIZE;
    localparam int KIDX_W        = $clog2(KERN_WORDS);
    localparam int TIDX_W        = $clog2(TILE_WORDS);

    typedef logic signed [DATA_W-1:0] sample_t;
    typedef logic signed [ACC_W-1:0]  acc_t;

    // index is (ch * side + row) * side + col
    typedef sample_t [KERN_WORDS-1:0] kernel_set_t;
    typedef sample_t [TILE_WORDS-1:0] tile_set_t;

    typedef struct packed {
        logic             kern_we;
        logic             tile_we;
        logic             shift;
        logic [CH_W-1:0]  ch;
        logic [POS_W-1:0] row;
        logic [POS_W-1:0] col;
    } buf_wr_t;

    typedef struct packed {
        logic go;
        logic dx;
        logic dy;
    } mac_req_t;

    typedef struct packed {
        logic valid;
        logic last;
        acc_t sum;
    } mac_res_t;

endpackage

`default_nettype wire
